/* common/mul_pkg.sv */
package mul_pkg;

	// operand width
	localparam int XLEN = 64;

	// two guard bits on each 66-bit extended operand
	localparam int PROD_W = 2 * XLEN + 2;

	// 66 extended multiplier bits, two per step
	localparam int BOOTH_STEPS = (XLEN + 2) / 2;

	typedef logic [XLEN-1:0] dword_t;

	typedef logic [PROD_W-1:0] prod_t;

	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		MULW   = 3'd4
	} mul_op_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		LOAD = 2'd1,
		STEP = 2'd2,
		DONE = 2'd3
	} booth_state_t;

endpackage

/* src/mul_req_queue.sv */
`timescale 1ns/1ns

module mul_req_queue import mul_pkg::*; #(
	parameter int REQ_DEPTH = 2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  mul_op_t req_op,
	input  dword_t  req_src1,
	input  dword_t  req_src2,
	output logic    req_credit,
	output logic    q_valid,
	output mul_op_t q_op,
	output dword_t  q_src1,
	output dword_t  q_src2,
	output logic    q_signed1,
	output logic    q_signed2,
	input  logic    q_take
);

	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1);

	mul_op_t op_mem [REQ_DEPTH];
	dword_t src1_mem [REQ_DEPTH];
	dword_t src2_mem [REQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(REQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(REQ_DEPTH));
	assign q_valid = (count != '0);
	assign pop = q_take & q_valid;
	assign req_credit = pop; // credit leaves with the entry

	always_ff @(posedge clk) begin
		if (req_valid) begin
			op_mem[wr_ptr] <= req_op;
			src1_mem[wr_ptr] <= req_src1;
			src2_mem[wr_ptr] <= req_src2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({req_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign q_op = op_mem[rd_ptr];
	assign q_src1 = src1_mem[rd_ptr];
	assign q_src2 = src2_mem[rd_ptr];

	// operand signedness from the op at the head
	always_comb begin
		case (q_op)
			MULHSU: {q_signed1, q_signed2} = 2'b10;
			MULHU: {q_signed1, q_signed2} = 2'b00;
			default: {q_signed1, q_signed2} = 2'b11; // MUL, MULH, MULW
		endcase
	end

	// sender must hold a credit for every request
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !full);

endmodule

/* booth_mul/booth_mul_core.sv */
`timescale 1ns/1ns

module booth_mul_core import mul_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    q_valid,
	input  mul_op_t q_op,
	input  dword_t  q_src1,
	input  dword_t  q_src2,
	input  logic    q_signed1,
	input  logic    q_signed2,
	output logic    q_take,
	output logic    prod_valid,
	output prod_t   prod,
	output mul_op_t prod_op,
	input  logic    prod_take
);

	localparam int CNT_W = $clog2(BOOTH_STEPS + 1);
	localparam int Y_W = XLEN + 3; // 66 multiplier bits and the zero below

	booth_state_t state;
	booth_state_t state_nxt;
	logic [CNT_W-1:0] step_cnt;
	logic last_step;

	dword_t src1_r;
	dword_t src2_r;
	logic sgn1_r;
	logic sgn2_r;
	mul_op_t op_r;

	prod_t x_r;
	prod_t acc_r;
	prod_t pp;
	logic [Y_W-1:0] y_r;

	assign q_take = (state == IDLE) & q_valid;
	assign last_step = (step_cnt == CNT_W'(BOOTH_STEPS - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (q_valid) state_nxt = LOAD;
			LOAD: state_nxt = STEP;
			STEP: if (last_step) state_nxt = DONE;
			DONE: if (prod_take) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			step_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == LOAD)
				step_cnt <= '0;
			else if (state == STEP)
				step_cnt <= step_cnt + 1'b1;
		end
	end

	// radix-4 recoding of the current window
	always_comb begin
		case (y_r[2:0])
			3'b001, 3'b010: pp = x_r;
			3'b011: pp = x_r << 1;
			3'b100: pp = -(x_r << 1);
			3'b101, 3'b110: pp = -x_r;
			default: pp = '0; // 000, 111
		endcase
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (q_take) begin
					src1_r <= q_src1;
					src2_r <= q_src2;
					sgn1_r <= q_signed1;
					sgn2_r <= q_signed2;
					op_r <= q_op;
				end
			end
			LOAD: begin
				x_r <= {{(PROD_W - XLEN){sgn1_r & src1_r[XLEN-1]}}, src1_r};
				y_r <= {{2{sgn2_r & src2_r[XLEN-1]}}, src2_r, 1'b0};
				acc_r <= '0;
			end
			STEP: begin
				acc_r <= acc_r + pp;
				x_r <= x_r << 2;
				y_r <= {{2{y_r[Y_W-1]}}, y_r[Y_W-1:2]};
			end
			default: begin
				acc_r <= acc_r; // hold product in DONE
			end
		endcase
	end

	assign prod_valid = (state == DONE);
	assign prod = acc_r;
	assign prod_op = op_r;

	// fixed latency from take to product
	a_take_latency: assert property (@(posedge clk) disable iff (!rst_n)
		q_take |-> ##(BOOTH_STEPS + 2) prod_valid);

	a_step_bound: assert property (@(posedge clk) disable iff (!rst_n)
		step_cnt <= CNT_W'(BOOTH_STEPS));

endmodule

/* src/mul_result_fmt.sv */
`timescale 1ns/1ns

module mul_result_fmt import mul_pkg::*; #(
	parameter int RES_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    prod_valid,
	input  prod_t   prod,
	input  mul_op_t prod_op,
	output logic    prod_take,
	output logic    res_valid,
	output dword_t  res_data,
	input  logic    res_credit
);

	localparam int CR_W = $clog2(RES_CREDITS + 1);

	logic [CR_W-1:0] credits;
	dword_t res_sel;

	// a result in the output register still holds its credit
	assign prod_take = prod_valid & (credits > CR_W'(res_valid));

	always_comb begin
		case (prod_op)
			MUL: res_sel = prod[XLEN-1:0];
			MULW: res_sel = {{(XLEN - 32){prod[31]}}, prod[31:0]};
			default: res_sel = prod[2*XLEN-1:XLEN]; // high half
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			credits <= CR_W'(RES_CREDITS);
		end else begin
			res_valid <= prod_take;
			credits <= credits - CR_W'(res_valid) + CR_W'(res_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (prod_take)
			res_data <= res_sel;
	end

	a_res_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> credits != '0);

	// consumer returns no more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CR_W'(RES_CREDITS));

endmodule

/* src/mul_unit_top.sv */
`timescale 1ns/1ns

module mul_unit_top import mul_pkg::*; #(
	parameter int REQ_DEPTH   = 2,
	parameter int RES_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  mul_op_t req_op,
	input  dword_t  req_src1,
	input  dword_t  req_src2,
	output logic    req_credit,
	output logic    res_valid,
	output dword_t  res_data,
	input  logic    res_credit
);

	logic q_valid;
	mul_op_t q_op;
	dword_t q_src1;
	dword_t q_src2;
	logic q_signed1;
	logic q_signed2;
	logic q_take;

	logic prod_valid;
	prod_t prod;
	mul_op_t prod_op;
	logic prod_take;

	mul_req_queue #(
		.REQ_DEPTH (REQ_DEPTH)
	) i_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_src1   (req_src1),
		.req_src2   (req_src2),
		.req_credit (req_credit),
		.q_valid    (q_valid),
		.q_op       (q_op),
		.q_src1     (q_src1),
		.q_src2     (q_src2),
		.q_signed1  (q_signed1),
		.q_signed2  (q_signed2),
		.q_take     (q_take)
	);

	booth_mul_core i_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.q_valid    (q_valid),
		.q_op       (q_op),
		.q_src1     (q_src1),
		.q_src2     (q_src2),
		.q_signed1  (q_signed1),
		.q_signed2  (q_signed2),
		.q_take     (q_take),
		.prod_valid (prod_valid),
		.prod       (prod),
		.prod_op    (prod_op),
		.prod_take  (prod_take)
	);

	mul_result_fmt #(
		.RES_CREDITS (RES_CREDITS)
	) i_fmt (
		.clk        (clk),
		.rst_n      (rst_n),
		.prod_valid (prod_valid),
		.prod       (prod),
		.prod_op    (prod_op),
		.prod_take  (prod_take),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_credit (res_credit)
	);

endmodule

/* dv/tb_mul_unit.sv */
`timescale 1ns/1ns

module tb_mul_unit import mul_pkg::*; ();

	localparam int REQ_DEPTH = 2;
	localparam int RES_CREDITS = 2;
	localparam int NUM_REQ = 400;
	localparam int N_CORNER = 64; // corner operand pairs sent first
	localparam int TIMEOUT = NUM_REQ * 40 + 2000;
	localparam int HOLD_AT = 150;
	localparam int HOLD_LEN = 400; // cycles with credits withheld

	logic clk;
	logic rst_n;
	logic req_valid;
	mul_op_t req_op;
	dword_t req_src1;
	dword_t req_src2;
	logic req_credit;
	logic res_valid;
	dword_t res_data;
	logic res_credit;

	integer seed = 57;
	int cycle;
	int errors;
	int sent;
	int recv;
	int send_cnt;
	int req_cr_pulses;
	int res_cr_pulses;
	int hold_until;
	bit running;
	mul_op_t nxt_op;
	dword_t nxt_a;
	dword_t nxt_b;
	dword_t exp_q[$];
	mul_op_t op_q[$];
	int due_q[$]; // cycles at which consumer credits are due
	dword_t corner [8];

	mul_unit_top #(
		.REQ_DEPTH   (REQ_DEPTH),
		.RES_CREDITS (RES_CREDITS)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_src1   (req_src1),
		.req_src2   (req_src2),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_credit (res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// 128-bit product of the extended operands
	function automatic dword_t ref_result(mul_op_t op, dword_t a, dword_t b);
		logic [2*XLEN-1:0] ea;
		logic [2*XLEN-1:0] eb;
		logic [2*XLEN-1:0] p;
		ea = {{XLEN{a[XLEN-1] & (op != MULHU)}}, a};
		eb = {{XLEN{b[XLEN-1] & (op != MULHU) & (op != MULHSU)}}, b};
		p = ea * eb;
		case (op)
			MUL: return p[XLEN-1:0];
			MULW: return {{(XLEN - 32){p[31]}}, p[31:0]};
			default: return p[2*XLEN-1:XLEN];
		endcase
	endfunction

	task automatic check_result(dword_t got, dword_t exp, mul_op_t op);
		if (got !== exp) begin
			errors++;
			$display("Mismatch res_data op=%s got=%h exp=%h at %0t", op.name(), got, exp, $time);
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) begin
			errors++;
			$display("Wrong number of %s: got %0d, expected %0d", what, got, exp);
		end
	endtask

	always @(posedge clk) begin
		if (running) begin
			cycle++;
			if (req_credit) begin
				send_cnt++;
				req_cr_pulses++;
				if (req_cr_pulses > sent) begin
					errors++;
					$display("Request credit returned with no request queued at %0t", $time);
				end
			end
			if (send_cnt > REQ_DEPTH) begin
				errors++;
				$display("Sender holds more request credits than the queue depth");
			end
			if (sent < NUM_REQ && send_cnt > 0 && ($random(seed) & 3) != 0) begin
				if (sent < N_CORNER) begin
					nxt_op = mul_op_t'(sent % 5);
					nxt_a = corner[sent % 8];
					nxt_b = corner[(sent / 8) % 8];
				end else begin
					nxt_op = mul_op_t'(($random(seed) & 32'h7fffffff) % 5);
					nxt_a = {$random(seed), $random(seed)};
					nxt_b = {$random(seed), $random(seed)};
				end
				req_valid <= 1'b1;
				req_op <= nxt_op;
				req_src1 <= nxt_a;
				req_src2 <= nxt_b;
				exp_q.push_back(ref_result(nxt_op, nxt_a, nxt_b));
				op_q.push_back(nxt_op);
				sent++;
				send_cnt--;
			end else begin
				req_valid <= 1'b0;
			end

			if (res_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Result arrived with no request pending at %0t", $time);
				end else begin
					check_result(res_data, exp_q.pop_front(), op_q.pop_front());
				end
				recv++;
				due_q.push_back(cycle + ($random(seed) & 32'h7fffffff) % 21);
				if (recv > RES_CREDITS + res_cr_pulses) begin
					errors++;
					$display("More results sent than result credits allow at %0t", $time);
				end
				if (recv == HOLD_AT)
					hold_until = cycle + HOLD_LEN; // long back-pressure
			end
			if (res_credit)
				res_cr_pulses++;
			if (due_q.size() != 0 && due_q[0] <= cycle && cycle >= hold_until) begin
				res_credit <= 1'b1;
				void'(due_q.pop_front());
			end else begin
				res_credit <= 1'b0;
			end
		end
	end

	initial begin
		req_valid = 1'b0;
		req_op = MUL;
		req_src1 = '0;
		req_src2 = '0;
		res_credit = 1'b0;
		rst_n = 1'b0;
		running = 1'b0;
		cycle = 0;
		errors = 0;
		sent = 0;
		recv = 0;
		send_cnt = REQ_DEPTH;
		req_cr_pulses = 0;
		res_cr_pulses = 0;
		hold_until = 0;
		corner = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
			64'h0000_0000_8000_0000, 64'hffff_ffff_8000_0000, 64'h0000_0000_ffff_ffff};
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (20) begin
			@(negedge clk);
			if (req_credit || res_valid) begin
				errors++;
				$display("Handshake output high while idle after reset at %0t", $time);
			end
		end
		@(posedge clk);
		running <= 1'b1;
		while (!(sent == NUM_REQ && recv == NUM_REQ && due_q.size() == 0) && cycle < TIMEOUT)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (cycle >= TIMEOUT) begin
			errors++;
			$display("Timeout after %0d cycles with %0d of %0d results", cycle, recv, NUM_REQ);
		end
		check_count(sent, NUM_REQ, "requests sent");
		check_count(recv, sent, "results received");
		check_count(req_cr_pulses, sent, "request credit pulses");
		check_count(send_cnt, REQ_DEPTH, "sender credits at the end");
		$display("errors=%0d requests=%0d results=%0d req_credits=%0d res_credits=%0d",
			errors, sent, recv, req_cr_pulses, res_cr_pulses);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* compile.f */
common/mul_pkg.sv
src/mul_req_queue.sv
booth_mul/booth_mul_core.sv
src/mul_result_fmt.sv
src/mul_unit_top.sv
dv/tb_mul_unit.sv

/* Bender.yml */
package:
  name: mul_unit

sources:
  - common/mul_pkg.sv
  - src/mul_req_queue.sv
  - booth_mul/booth_mul_core.sv
  - src/mul_result_fmt.sv
  - src/mul_unit_top.sv
  - target: simulation
    files:
      - dv/tb_mul_unit.sv
